// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    ///////////////////////////////////////////////////////////////////////
    // Widths and reset address
    ///////////////////////////////////////////////////////////////////////

    localparam int PC_WIDTH   = 30;                 // Word address, byte offset dropped
    localparam int WORD_WIDTH = 32;                 // Bus word and instruction

    // Byte address of the first instruction
    localparam logic [31:0] RESET_VECTOR = 32'h0000_0000;

    ///////////////////////////////////////////////////////////////////////
    // Vector types
    ///////////////////////////////////////////////////////////////////////

    typedef logic [PC_WIDTH-1:0]   pc_t;            // Word address
    typedef logic [WORD_WIDTH-1:0] word_t;          // Bus address or data
    typedef logic [WORD_WIDTH-1:0] instr_t;         // Instruction word

    // One word before the vector, first fetch lands on it
    localparam pc_t RESET_PC = PC_WIDTH'((RESET_VECTOR >> 2) - 32'd1);

    ///////////////////////////////////////////////////////////////////////
    // Grouped signals
    ///////////////////////////////////////////////////////////////////////

    // Per-stage stall bits from the pipeline control
    typedef struct packed {
        logic a;                                    // A stage, next address
        logic f;                                    // F stage, fetch
        logic d;                                    // D stage, decode
        logic x;                                    // X stage, execute
        logic m;                                    // M stage, memory
    } stall_t;

    // Redirect request from a later stage
    typedef struct packed {
        logic taken;                                // Branch is taken
        pc_t  target;                               // Word address to fetch next
    } branch_req_t;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic  cyc;
        logic  stb;
        word_t adr;                                 // Byte address
    } wb_req_t;

    // Wishbone classic, slave to master
    typedef struct packed {
        word_t dat;
        logic  ack;
        logic  err;
    } wb_rsp_t;

    // Fetch master states
    typedef enum logic {
        FETCH_IDLE,                                 // No cycle on the bus
        FETCH_WAIT                                  // Cycle open, waiting for ack or err
    } fetch_state_t;

endpackage

// ==== rtl/pc_pipeline.sv ====
module pc_pipeline (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    // Pipeline control
    input  fetch_pkg::stall_t      stall_i,         // Per-stage stalls
    input  fetch_pkg::branch_req_t branch_x_i,      // Redirect from X stage
    input  fetch_pkg::branch_req_t branch_m_i,      // Redirect from M stage
    // Stage PCs
    output fetch_pkg::pc_t         pc_a_o,          // Next fetch address, combinational
    output fetch_pkg::pc_t         pc_f_o,
    output fetch_pkg::pc_t         pc_d_o,
    output fetch_pkg::pc_t         pc_x_o,
    output fetch_pkg::pc_t         pc_m_o
);

    ///////////////////////////////////////////////////////////////////////
    // Internal signals
    ///////////////////////////////////////////////////////////////////////

    fetch_pkg::pc_t pc_a;                           // A stage, not registered
    fetch_pkg::pc_t pc_f;                           // Instruction being fetched
    fetch_pkg::pc_t pc_d;                           // Instruction in decode
    fetch_pkg::pc_t pc_x;                           // Instruction in execute
    fetch_pkg::pc_t pc_m;                           // Instruction in memory stage
    fetch_pkg::pc_t pc_seq;                         // Sequential successor of pc_f

    ///////////////////////////////////////////////////////////////////////
    // Next address selection
    ///////////////////////////////////////////////////////////////////////

    // Next word, wraps at the top of the space
    assign pc_seq = pc_f + fetch_pkg::pc_t'(1);

    // Later stage wins, its branch is older in program order
    always_comb
    begin
        if (branch_m_i.taken)
        begin
            pc_a = branch_m_i.target;               // M stage redirect
        end
        else if (branch_x_i.taken)
        begin
            pc_a = branch_x_i.target;               // X stage redirect
        end
        else
        begin
            pc_a = pc_seq;                          // Straight-line fetch
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Stage registers
    ///////////////////////////////////////////////////////////////////////

    // Each stage holds while its own stall is set
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            pc_f <= fetch_pkg::RESET_PC;            // Word before the vector
            pc_d <= '0;
            pc_x <= '0;
            pc_m <= '0;
        end
        else
        begin
            // F stage
            if (!stall_i.f)
            begin
                pc_f <= pc_a;
            end
            // D stage
            if (!stall_i.d)
            begin
                pc_d <= pc_f;
            end
            // X stage
            if (!stall_i.x)
            begin
                pc_x <= pc_d;
            end
            // M stage
            if (!stall_i.m)
            begin
                pc_m <= pc_x;
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Outputs
    ///////////////////////////////////////////////////////////////////////

    assign pc_a_o = pc_a;                           // To the fetch master
    assign pc_f_o = pc_f;
    assign pc_d_o = pc_d;
    assign pc_x_o = pc_x;
    assign pc_m_o = pc_m;

endmodule

// ==== rtl/wb_fetch.sv ====
module wb_fetch (
    input  logic               clk_i,
    input  logic               rst_n_i,
    // Pipeline control
    input  fetch_pkg::stall_t  stall_i,             // Uses the a and d bits
    input  fetch_pkg::pc_t     pc_a_i,              // A stage word address
    // Wishbone classic master
    input  fetch_pkg::wb_rsp_t wb_rsp_i,
    output fetch_pkg::wb_req_t wb_req_o,
    // D stage
    output fetch_pkg::instr_t  instruction_d_o,     // Instruction to decode
    output logic               bus_error_d_o        // Fetch of that word failed
);

    ///////////////////////////////////////////////////////////////////////
    // Internal signals
    ///////////////////////////////////////////////////////////////////////

    fetch_pkg::fetch_state_t state_q;               // Current FSM state
    fetch_pkg::fetch_state_t state_d;               // Next FSM state
    fetch_pkg::word_t        adr_q;                 // Byte address of open cycle
    fetch_pkg::instr_t       instruction_f_q;       // Last word returned by the slave
    logic                    bus_error_f_q;         // Last fetch ended with err
    fetch_pkg::instr_t       instruction_d_q;
    logic                    bus_error_d_q;
    logic                    start_fetch;           // Open a cycle at the next edge
    logic                    fetch_done;            // Slave ends the cycle this edge

    ///////////////////////////////////////////////////////////////////////
    // Fetch FSM
    ///////////////////////////////////////////////////////////////////////

    // Only from idle, so one idle cycle always follows a fetch
    assign start_fetch = (state_q == fetch_pkg::FETCH_IDLE) && !stall_i.a;

    // stb is high in FETCH_WAIT, so ack or err here closes the cycle
    assign fetch_done = (state_q == fetch_pkg::FETCH_WAIT)
                        && (wb_rsp_i.ack || wb_rsp_i.err);

    always_comb
    begin
        state_d = state_q;                          // Hold by default
        case (state_q)
            fetch_pkg::FETCH_IDLE:
            begin
                if (start_fetch)
                begin
                    state_d = fetch_pkg::FETCH_WAIT;
                end
            end
            fetch_pkg::FETCH_WAIT:
            begin
                // Wait states just keep us here
                if (fetch_done)
                begin
                    state_d = fetch_pkg::FETCH_IDLE;
                end
            end
            default:
            begin
                state_d = fetch_pkg::FETCH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            state_q <= fetch_pkg::FETCH_IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    // Address latched once per cycle, stable until ack or err
    always_ff @(posedge clk_i)
    begin
        if (start_fetch)
        begin
            adr_q <= {pc_a_i, 2'b00};               // Word to byte address
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // F stage capture
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            instruction_f_q <= '0;
            bus_error_f_q   <= 1'b0;
        end
        else if (start_fetch)
        begin
            bus_error_f_q <= 1'b0;                  // New fetch, old error gone
        end
        else if (fetch_done)
        begin
            instruction_f_q <= wb_rsp_i.dat;        // Taken on err as well
            bus_error_f_q   <= wb_rsp_i.err;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // D stage instruction register
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            instruction_d_q <= '0;
            bus_error_d_q   <= 1'b0;
        end
        else if (!stall_i.d)
        begin
            instruction_d_q <= instruction_f_q;
            bus_error_d_q   <= bus_error_f_q;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Outputs
    ///////////////////////////////////////////////////////////////////////

    // Single reads only, cyc and stb move together
    always_comb
    begin
        wb_req_o.cyc = (state_q == fetch_pkg::FETCH_WAIT);
        wb_req_o.stb = (state_q == fetch_pkg::FETCH_WAIT);
        wb_req_o.adr = adr_q;
    end

    assign instruction_d_o = instruction_d_q;
    assign bus_error_d_o   = bus_error_d_q;

endmodule

// ==== rtl/instr_unit.sv ====
module instr_unit (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    // Pipeline control
    input  fetch_pkg::stall_t      stall_i,
    input  fetch_pkg::branch_req_t branch_x_i,      // X stage redirect
    input  fetch_pkg::branch_req_t branch_m_i,      // M stage redirect, higher priority
    // Instruction bus
    input  fetch_pkg::wb_rsp_t     wb_rsp_i,
    output fetch_pkg::wb_req_t     wb_req_o,
    // Stage PCs
    output fetch_pkg::pc_t         pc_f_o,
    output fetch_pkg::pc_t         pc_d_o,
    output fetch_pkg::pc_t         pc_x_o,
    output fetch_pkg::pc_t         pc_m_o,
    // Decode stage
    output fetch_pkg::instr_t      instruction_d_o,
    output logic                   bus_error_d_o
);

    ///////////////////////////////////////////////////////////////////////
    // Internal wires
    ///////////////////////////////////////////////////////////////////////

    fetch_pkg::pc_t pc_a;                           // Next fetch address

    ///////////////////////////////////////////////////////////////////////
    // PC pipeline
    ///////////////////////////////////////////////////////////////////////

    pc_pipeline u_pc_pipeline (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .stall_i    (stall_i),
        .branch_x_i (branch_x_i),
        .branch_m_i (branch_m_i),
        .pc_a_o     (pc_a),
        .pc_f_o     (pc_f_o),
        .pc_d_o     (pc_d_o),
        .pc_x_o     (pc_x_o),
        .pc_m_o     (pc_m_o)
    );

    ///////////////////////////////////////////////////////////////////////
    // Wishbone fetch master
    ///////////////////////////////////////////////////////////////////////

    // Fetches from pc_a, hands the word to decode
    wb_fetch u_wb_fetch (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .stall_i         (stall_i),
        .pc_a_i          (pc_a),
        .wb_rsp_i        (wb_rsp_i),
        .wb_req_o        (wb_req_o),
        .instruction_d_o (instruction_d_o),
        .bus_error_d_o   (bus_error_d_o)
    );

endmodule

// ==== verification/fetch_model.svh ====
`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

///////////////////////////////////////////////////////////////////////
// Model state
///////////////////////////////////////////////////////////////////////

logic [31:0]       rng_state     = 32'h03623068;        // Fixed seed
fetch_pkg::pc_t    model_pc_f    = fetch_pkg::RESET_PC; // Word before the vector
fetch_pkg::pc_t    model_pc_d    = '0;
fetch_pkg::pc_t    model_pc_x    = '0;
fetch_pkg::pc_t    model_pc_m    = '0;
logic              model_busy    = 1'b0;                // Cycle open on the bus
fetch_pkg::word_t  model_adr     = '0;                  // Byte address of that cycle
fetch_pkg::instr_t last_dat      = '0;                  // Most recent completed fetch
logic              last_err      = 1'b0;                // Low while a newer fetch is open
fetch_pkg::instr_t model_instr_d = '0;
logic              model_err_d   = 1'b0;
logic              slave_busy    = 1'b0;                // Request already seen
int unsigned       wait_left     = 0;                   // Wait states still to insert
fetch_pkg::word_t  resp_dat      = '0;                  // Last response from the slave
logic              resp_err      = 1'b0;

// xorshift32
function logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
endfunction

///////////////////////////////////////////////////////////////////////
// Reference pipeline and bus slave
///////////////////////////////////////////////////////////////////////

// One rising edge with the inputs seen just before it
task step_model(input fetch_pkg::stall_t st, input fetch_pkg::branch_req_t bx,
                input fetch_pkg::branch_req_t bm, input logic done);
    fetch_pkg::pc_t pc_a;
    pc_a = bm.taken ? bm.target                         // M stage redirect wins
         : bx.taken ? bx.target : model_pc_f + fetch_pkg::pc_t'(1);
    // Back to front so each stage takes the old value
    if (!st.m)
        model_pc_m = model_pc_x;
    if (!st.x)
        model_pc_x = model_pc_d;
    if (!st.d)
    begin
        model_pc_d    = model_pc_f;
        model_instr_d = last_dat;                       // F stage word before the edge
        model_err_d   = last_err;
    end
    if (!st.f)
        model_pc_f = pc_a;
    // Fetch master idles at least one cycle between requests
    if (!model_busy && !st.a)
    begin
        model_busy = 1'b1;
        model_adr  = {pc_a, 2'b00};
        last_err   = 1'b0;                              // Newer fetch still open
    end
    else if (model_busy && done)
    begin
        model_busy = 1'b0;
        last_dat   = resp_dat;                          // As recorded by the slave
        last_err   = resp_err;
    end
endtask

// Answers the open request after 0 to 3 wait states
task respond_to_bus(input fetch_pkg::wb_req_t req, output fetch_pkg::wb_rsp_t rsp);
    rsp = '0;
    if (!req.cyc || !req.stb)
    begin
        slave_busy = 1'b0;                              // Bus idle or cycle just ended
    end
    else
    begin
        if (!slave_busy)
            wait_left = next_random() % 4;              // New request
        slave_busy = 1'b1;
        if (wait_left != 0)
            wait_left--;
        else
        begin
            resp_dat = next_random();
            resp_err = (next_random() % 8 == 0);        // err one time in eight
            rsp      = {resp_dat, ~resp_err, resp_err};
        end
    end
endtask

`endif

// ==== verification/tb_instr_unit.sv ====
module tb_instr_unit;

    localparam int NUM_CYCLES     = 2000;                           // Random cycles after reset
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + NUM_CYCLES / 4;    // Run plus a quarter

    logic                   clk;
    logic                   rst_n;
    fetch_pkg::stall_t      stall;
    fetch_pkg::branch_req_t branch_x;
    fetch_pkg::branch_req_t branch_m;
    fetch_pkg::wb_rsp_t     wb_rsp;                 // From the slave model
    fetch_pkg::wb_req_t     wb_req;
    fetch_pkg::pc_t         pc_f;
    fetch_pkg::pc_t         pc_d;
    fetch_pkg::pc_t         pc_x;
    fetch_pkg::pc_t         pc_m;
    fetch_pkg::instr_t      instruction_d;
    logic                   bus_error_d;
    int                     check_count = 0;
    int                     error_count = 0;
    int                     cycle_count = 0;        // Rising edges seen

    `include "fetch_model.svh"

    instr_unit UUT (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .stall_i         (stall),
        .branch_x_i      (branch_x),
        .branch_m_i      (branch_m),
        .wb_rsp_i        (wb_rsp),
        .wb_req_o        (wb_req),
        .pc_f_o          (pc_f),
        .pc_d_o          (pc_d),
        .pc_x_o          (pc_x),
        .pc_m_o          (pc_m),
        .instruction_d_o (instruction_d),
        .bus_error_d_o   (bus_error_d)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #20 clk = ~clk;                         // Period 40
    end

    task check_value(input string name, input logic [31:0] actual, input logic [31:0] expected);
        check_count++;
        assert (actual === expected)
        else
        begin
            error_count++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // Compared mid-cycle once all outputs have settled
    task check_outputs();
        check_value("pc_f", 32'(pc_f), 32'(model_pc_f));
        check_value("pc_d", 32'(pc_d), 32'(model_pc_d));
        check_value("pc_x", 32'(pc_x), 32'(model_pc_x));
        check_value("pc_m", 32'(pc_m), 32'(model_pc_m));
        check_value("wb_req.cyc", 32'(wb_req.cyc), 32'(model_busy));
        check_value("wb_req.stb", 32'(wb_req.stb), 32'(model_busy));
        if (model_busy)
            check_value("wb_req.adr", wb_req.adr, model_adr);   // Held until ack or err
        check_value("instruction_d", instruction_d, model_instr_d);
        check_value("bus_error_d", 32'(bus_error_d), 32'(model_err_d));
    endtask

    // New stalls and branches for the coming edge
    task drive_pipeline_inputs();
        logic [31:0] r;
        int          k;
        r = next_random();
        for (k = 0; k < 5; k++)
            stall[k] = (r[2*k +: 2] == 2'd0);       // Each bit one time in four
        branch_x.taken  = (r[12:10] == 3'd0);       // One time in eight
        branch_x.target = fetch_pkg::pc_t'(next_random());
        branch_m.taken  = (r[15:13] == 3'd0);
        branch_m.target = fetch_pkg::pc_t'(next_random());
    endtask

    initial
    begin
        rst_n    = 1'b0;
        stall    = '0;
        branch_x = '0;
        branch_m = '0;
        wb_rsp   = '0;
        repeat (2)
        begin
            @(posedge clk);
            #2;
            check_outputs();                        // Reset values
        end
        rst_n = 1'b1;
        repeat (NUM_CYCLES)
        begin
            drive_pipeline_inputs();
            respond_to_bus(wb_req, wb_rsp);
            @(negedge clk);
            check_outputs();
            step_model(stall, branch_x, branch_m, wb_rsp.ack || wb_rsp.err);
            @(posedge clk);
            #2;                                     // Inputs move just after the edge
        end
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // Hard stop
    initial
    begin
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run timed out after %0d cycles", cycle_count);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== instr_unit.f ====
+incdir+verification
common/fetch_pkg.sv
rtl/pc_pipeline.sv
rtl/wb_fetch.sv
rtl/instr_unit.sv
verification/tb_instr_unit.sv

// ==== Makefile ====
# Verilator build and regression run for the fetch stage

VERILATOR ?= verilator
TOP       ?= tb_instr_unit
FILELIST  ?= instr_unit.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Override VERILATOR, TOP, FILELIST, OBJ_DIR, LOG or VFLAGS on the command line"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Regression passed" $(LOG) || { echo "test: FAIL, see $(LOG)"; exit 1; }
	@echo "test: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
